// File: src/rvseed_isa_pkg.sv
package rvseed_isa_pkg;

    localparam int xlen       = 64;
    localparam int imem_depth = 64;

    typedef logic [31:0]                     inst_t;
    typedef logic [xlen-1:0]                 xword_t;
    typedef logic [xlen-1:0]                 pc_t;
    typedef logic [4:0]                      reg_addr_t;
    typedef logic [$clog2(imem_depth)-1:0]   imem_addr_t;

    typedef logic [6:0]                      opcode_t;
    typedef logic [2:0]                      funct3_t;
    typedef logic [6:0]                      funct7_t;

    // major opcodes, inst[6:0]
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg_w  = 7'b0111011;
    localparam opcode_t op_imm_w  = 7'b0011011;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_branch = 7'b1100011;

    // funct3, inst[14:12]
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_addi    = 3'b000;
    localparam funct3_t f3_sltiu   = 3'b011;
    localparam funct3_t f3_jalr    = 3'b000;
    localparam funct3_t f3_beq     = 3'b000;
    localparam funct3_t f3_bne     = 3'b001;

    // funct7, inst[31:25]
    localparam funct7_t funct7_add = 7'b0000000;
    localparam funct7_t funct7_sub = 7'b0100000;

    localparam inst_t inst_ebreak = 32'h0010_0073;

endpackage

// File: src/rvseed_ctrl_pkg.sv
package rvseed_ctrl_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_sltu,
        alu_eq,
        alu_ne
    } alu_op_e;

    typedef enum logic [1:0] {
        src_reg,        // rs1 op rs2
        src_imm,        // rs1 op imm
        src_imm_pc,     // pc + imm
        src_four_pc     // pc + 4, link value
    } alu_src_e;

    typedef enum logic [1:0] {
        imm_i,
        imm_u,
        imm_j,
        imm_b
    } imm_kind_e;

    typedef struct packed {
        logic      branch;
        logic      jump;
        logic      jalr;
        logic      reg_wen;
        logic      word_op;     // sign-extend low 32 bits
        logic      rs1_used;
        alu_op_e   alu_op;
        alu_src_e  alu_src;
        imm_kind_e imm_kind;
        logic      ebreak;
        logic      illegal;
    } ctrl_t;

    typedef struct packed {
        rvseed_isa_pkg::pc_t   pc;
        rvseed_isa_pkg::inst_t inst;
    } fetch_t;

    typedef struct packed {
        rvseed_isa_pkg::pc_t       pc;
        rvseed_isa_pkg::reg_addr_t rd;
        logic                      reg_wen;
        rvseed_isa_pkg::xword_t    wdata;
    } retire_t;

endpackage

// File: src/inst_fetch.sv
`timescale 1ns/1ps

module inst_fetch (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          run,
    input  logic                          imem_we,
    input  rvseed_isa_pkg::imem_addr_t    imem_addr,
    input  rvseed_isa_pkg::inst_t         imem_wdata,
    input  logic                          full,
    input  logic                          redirect,
    input  rvseed_isa_pkg::pc_t           redirect_pc,
    input  logic                          halted,
    output logic                          push,
    output rvseed_ctrl_pkg::fetch_t       push_data
);

    rvseed_isa_pkg::inst_t      imem [0:rvseed_isa_pkg::imem_depth-1];
    rvseed_isa_pkg::pc_t        pc;
    rvseed_isa_pkg::imem_addr_t rd_idx;

    assign rd_idx = pc[7:2];   // word index

    // redirect cycle carries a wrong-path word, drop it
    assign push = run & ~halted & ~full & ~redirect;

    assign push_data.pc   = pc;
    assign push_data.inst = imem[rd_idx];

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (push) begin
            pc <= pc + 64'd4;
        end
    end

endmodule

// File: src/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          push,
    input  rvseed_ctrl_pkg::fetch_t       push_data,
    input  logic                          pop,
    input  logic                          flush,
    output logic                          full,
    output logic                          empty,
    output rvseed_ctrl_pkg::fetch_t       head
);

    rvseed_ctrl_pkg::fetch_t mem [0:1];
    logic [1:0]              count;
    logic                    wr_ptr;
    logic                    rd_ptr;
    logic                    do_push;
    logic                    do_pop;

    assign full  = (count == 2'd2);
    assign empty = (count == 2'd0);
    assign head  = mem[rd_ptr];

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count  <= 2'd0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else if (flush) begin   // flush wins over push and pop
            count  <= 2'd0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (do_pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + 2'(do_push) - 2'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: src/ctrl.sv
`timescale 1ns/1ps

module ctrl (
    input  rvseed_isa_pkg::inst_t   inst,
    output rvseed_ctrl_pkg::ctrl_t  ctrl
);

    rvseed_isa_pkg::opcode_t opcode;
    rvseed_isa_pkg::funct3_t funct3;
    rvseed_isa_pkg::funct7_t funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        ctrl.branch   = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.jalr     = 1'b0;
        ctrl.reg_wen  = 1'b0;
        ctrl.word_op  = 1'b0;
        ctrl.rs1_used = 1'b0;
        ctrl.alu_op   = rvseed_ctrl_pkg::alu_add;
        ctrl.alu_src  = rvseed_ctrl_pkg::src_reg;
        ctrl.imm_kind = rvseed_ctrl_pkg::imm_i;
        ctrl.ebreak   = 1'b0;
        ctrl.illegal  = 1'b0;

        case (opcode)
            rvseed_isa_pkg::op_reg, rvseed_isa_pkg::op_reg_w: begin
                if (funct3 == rvseed_isa_pkg::f3_add_sub &&
                    funct7 == rvseed_isa_pkg::funct7_add) begin
                    ctrl.reg_wen  = 1'b1;
                    ctrl.rs1_used = 1'b1;
                    ctrl.word_op  = (opcode == rvseed_isa_pkg::op_reg_w);   // addw
                end else if (opcode == rvseed_isa_pkg::op_reg &&
                             funct3 == rvseed_isa_pkg::f3_add_sub &&
                             funct7 == rvseed_isa_pkg::funct7_sub) begin
                    ctrl.reg_wen  = 1'b1;
                    ctrl.rs1_used = 1'b1;
                    ctrl.alu_op   = rvseed_ctrl_pkg::alu_sub;
                end else begin
                    ctrl.illegal  = 1'b1;
                end
            end
            rvseed_isa_pkg::op_imm: begin
                case (funct3)
                    rvseed_isa_pkg::f3_addi: begin
                        ctrl.reg_wen  = 1'b1;
                        ctrl.rs1_used = 1'b1;
                        ctrl.alu_src  = rvseed_ctrl_pkg::src_imm;
                    end
                    rvseed_isa_pkg::f3_sltiu: begin
                        ctrl.reg_wen  = 1'b1;
                        ctrl.rs1_used = 1'b1;
                        ctrl.alu_op   = rvseed_ctrl_pkg::alu_sltu;
                        ctrl.alu_src  = rvseed_ctrl_pkg::src_imm;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            rvseed_isa_pkg::op_imm_w: begin
                if (funct3 == rvseed_isa_pkg::f3_addi) begin   // addiw
                    ctrl.reg_wen  = 1'b1;
                    ctrl.rs1_used = 1'b1;
                    ctrl.word_op  = 1'b1;
                    ctrl.alu_src  = rvseed_ctrl_pkg::src_imm;
                end else begin
                    ctrl.illegal  = 1'b1;
                end
            end
            rvseed_isa_pkg::op_lui: begin
                ctrl.reg_wen  = 1'b1;   // x0 + imm
                ctrl.alu_src  = rvseed_ctrl_pkg::src_imm;
                ctrl.imm_kind = rvseed_ctrl_pkg::imm_u;
            end
            rvseed_isa_pkg::op_auipc: begin
                ctrl.reg_wen  = 1'b1;
                ctrl.alu_src  = rvseed_ctrl_pkg::src_imm_pc;
                ctrl.imm_kind = rvseed_ctrl_pkg::imm_u;
            end
            rvseed_isa_pkg::op_jal: begin
                ctrl.jump     = 1'b1;
                ctrl.reg_wen  = 1'b1;
                ctrl.alu_src  = rvseed_ctrl_pkg::src_four_pc;
                ctrl.imm_kind = rvseed_ctrl_pkg::imm_j;
            end
            rvseed_isa_pkg::op_jalr: begin
                if (funct3 == rvseed_isa_pkg::f3_jalr) begin
                    ctrl.jump     = 1'b1;
                    ctrl.jalr     = 1'b1;
                    ctrl.reg_wen  = 1'b1;
                    ctrl.rs1_used = 1'b1;   // target base
                    ctrl.alu_src  = rvseed_ctrl_pkg::src_four_pc;
                end else begin
                    ctrl.illegal  = 1'b1;
                end
            end
            rvseed_isa_pkg::op_branch: begin
                ctrl.rs1_used = 1'b1;
                ctrl.imm_kind = rvseed_ctrl_pkg::imm_b;
                case (funct3)
                    rvseed_isa_pkg::f3_beq: begin
                        ctrl.branch = 1'b1;
                        ctrl.alu_op = rvseed_ctrl_pkg::alu_eq;
                    end
                    rvseed_isa_pkg::f3_bne: begin
                        ctrl.branch = 1'b1;
                        ctrl.alu_op = rvseed_ctrl_pkg::alu_ne;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            default: ctrl.illegal = 1'b1;   // loads, stores, system and the rest
        endcase

        if (inst == rvseed_isa_pkg::inst_ebreak) begin
            ctrl.ebreak  = 1'b1;
            ctrl.illegal = 1'b0;
        end
    end

endmodule

// File: src/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          empty,
    input  rvseed_ctrl_pkg::fetch_t       head,
    output logic                          pop,
    output logic                          redirect,
    output rvseed_isa_pkg::pc_t           redirect_pc,
    output logic                          retire_valid,
    output rvseed_ctrl_pkg::retire_t      retire,
    output logic                          illegal_valid,
    output rvseed_isa_pkg::inst_t         illegal_inst,
    output logic                          halted
);

    rvseed_ctrl_pkg::ctrl_t    dec;
    rvseed_isa_pkg::reg_addr_t rs1;
    rvseed_isa_pkg::reg_addr_t rs2;
    rvseed_isa_pkg::reg_addr_t rd;
    rvseed_isa_pkg::xword_t    regs [0:31];
    rvseed_isa_pkg::xword_t    rs1_val;
    rvseed_isa_pkg::xword_t    rs2_val;
    rvseed_isa_pkg::xword_t    imm;
    rvseed_isa_pkg::xword_t    alu_a;
    rvseed_isa_pkg::xword_t    alu_b;
    rvseed_isa_pkg::xword_t    alu_res;
    rvseed_isa_pkg::xword_t    wdata;
    rvseed_isa_pkg::pc_t       target;
    logic                      taken;

    ctrl u_ctrl (
        .inst (head.inst),
        .ctrl (dec)
    );

    assign rs1 = head.inst[19:15];
    assign rs2 = head.inst[24:20];
    assign rd  = head.inst[11:7];

    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];   // x0 reads zero
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    // the cycle after a redirect holds a wrong-path head
    assign pop = ~empty & ~halted & ~redirect;

    always_comb begin
        case (dec.imm_kind)
            rvseed_ctrl_pkg::imm_u: imm = {{32{head.inst[31]}}, head.inst[31:12], 12'b0};
            rvseed_ctrl_pkg::imm_j: imm = {{44{head.inst[31]}}, head.inst[19:12], head.inst[20],
                                           head.inst[30:21], 1'b0};
            rvseed_ctrl_pkg::imm_b: imm = {{52{head.inst[31]}}, head.inst[7], head.inst[30:25],
                                           head.inst[11:8], 1'b0};
            default:                imm = {{52{head.inst[31]}}, head.inst[31:20]};
        endcase
    end

    assign alu_a = (dec.alu_src == rvseed_ctrl_pkg::src_imm_pc ||
                    dec.alu_src == rvseed_ctrl_pkg::src_four_pc) ? head.pc :
                   (dec.rs1_used ? rs1_val : '0);   // lui adds to zero

    always_comb begin
        case (dec.alu_src)
            rvseed_ctrl_pkg::src_reg:     alu_b = rs2_val;
            rvseed_ctrl_pkg::src_four_pc: alu_b = 64'd4;
            default:                      alu_b = imm;
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            rvseed_ctrl_pkg::alu_sub:  alu_res = alu_a - alu_b;
            rvseed_ctrl_pkg::alu_sltu: alu_res = rvseed_isa_pkg::xword_t'(alu_a < alu_b);
            rvseed_ctrl_pkg::alu_eq:   alu_res = rvseed_isa_pkg::xword_t'(alu_a == alu_b);
            rvseed_ctrl_pkg::alu_ne:   alu_res = rvseed_isa_pkg::xword_t'(alu_a != alu_b);
            default:                   alu_res = alu_a + alu_b;
        endcase
    end

    assign wdata  = dec.word_op ? {{32{alu_res[31]}}, alu_res[31:0]} : alu_res;
    assign taken  = dec.jump | (dec.branch & alu_res[0]);
    assign target = (dec.jalr ? rs1_val : head.pc) + imm;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid  <= 1'b0;
            illegal_valid <= 1'b0;
            redirect      <= 1'b0;
            halted        <= 1'b0;
        end else begin
            retire_valid  <= pop & ~dec.illegal & ~dec.ebreak;
            illegal_valid <= pop & dec.illegal;
            redirect      <= pop & taken;
            if (pop & dec.ebreak) begin
                halted <= 1'b1;   // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            retire.pc      <= head.pc;
            retire.rd      <= dec.reg_wen ? rd : '0;
            retire.reg_wen <= dec.reg_wen;
            retire.wdata   <= dec.reg_wen ? wdata : '0;
            illegal_inst   <= head.inst;
            redirect_pc    <= {target[rvseed_isa_pkg::xlen-1:1], 1'b0};
        end
        if (pop & dec.reg_wen & (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

endmodule

// File: src/rvseed_core.sv
`timescale 1ns/1ps

module rvseed_core (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          run,
    input  logic                          imem_we,
    input  rvseed_isa_pkg::imem_addr_t    imem_addr,
    input  rvseed_isa_pkg::inst_t         imem_wdata,
    output logic                          retire_valid,
    output rvseed_ctrl_pkg::retire_t      retire,
    output logic                          illegal_valid,
    output rvseed_isa_pkg::inst_t         illegal_inst,
    output logic                          halted
);

    logic                    push;
    logic                    full;
    logic                    empty;
    logic                    pop;
    logic                    redirect;
    rvseed_ctrl_pkg::fetch_t push_data;
    rvseed_ctrl_pkg::fetch_t head;
    rvseed_isa_pkg::pc_t     redirect_pc;

    inst_fetch u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .full        (full),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halted      (halted),
        .push        (push),
        .push_data   (push_data)
    );

    fetch_queue u_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .flush     (redirect),
        .full      (full),
        .empty     (empty),
        .head      (head)
    );

    exec_unit u_exec (
        .clk           (clk),
        .arst_n        (arst_n),
        .empty         (empty),
        .head          (head),
        .pop           (pop),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .retire_valid  (retire_valid),
        .retire        (retire),
        .illegal_valid (illegal_valid),
        .illegal_inst  (illegal_inst),
        .halted        (halted)
    );

endmodule

// File: tests/tb_rvseed_core.sv
`timescale 1ns/1ps

module tb_rvseed_core;

    logic                          clk;
    logic                          arst_n;
    logic                          run;
    logic                          imem_we;
    rvseed_isa_pkg::imem_addr_t    imem_addr;
    rvseed_isa_pkg::inst_t         imem_wdata;
    logic                          retire_valid;
    rvseed_ctrl_pkg::retire_t      retire;
    logic                          illegal_valid;
    rvseed_isa_pkg::inst_t         illegal_inst;
    logic                          halted;

    rvseed_isa_pkg::inst_t         prog [0:63];
    int                            prog_len;
    rvseed_ctrl_pkg::retire_t      exp_ret [$];
    rvseed_ctrl_pkg::retire_t      act_ret [$];
    rvseed_isa_pkg::inst_t         exp_ill [$];
    rvseed_isa_pkg::inst_t         act_ill [$];
    int                            test_errors;
    int                            pass_count;
    int                            fail_count;

    rvseed_core uut (
        .clk           (clk),
        .arst_n        (arst_n),
        .run           (run),
        .imem_we       (imem_we),
        .imem_addr     (imem_addr),
        .imem_wdata    (imem_wdata),
        .retire_valid  (retire_valid),
        .retire        (retire),
        .illegal_valid (illegal_valid),
        .illegal_inst  (illegal_inst),
        .halted        (halted)
    );

    always #50 clk = ~clk;

    function automatic rvseed_isa_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                                    input logic [2:0] f3, input logic [4:0] rd,
                                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rvseed_isa_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                                    input logic [4:0] rs1, input logic [4:0] rd,
                                                    input logic [6:0] op);
        return {f7, rs2, rs1, 3'b000, rd, op};
    endfunction

    function automatic rvseed_isa_pkg::inst_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                                    input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvseed_isa_pkg::op_branch};
    endfunction

    function automatic rvseed_isa_pkg::inst_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvseed_isa_pkg::op_jal};
    endfunction

    function automatic rvseed_isa_pkg::inst_t enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                                       input logic [11:0] imm);
        return enc_i(imm, rs1, 3'b000, rd, rvseed_isa_pkg::op_imm);
    endfunction

    task automatic emit(input rvseed_isa_pkg::inst_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic check_retire(input string name, input rvseed_ctrl_pkg::retire_t exp,
                                input rvseed_ctrl_pkg::retire_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_illegal(input string name, input rvseed_isa_pkg::inst_t exp,
                                 input rvseed_isa_pkg::inst_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    // ISA model walks the program from pc 0 up to ebreak
    task automatic run_model();
        rvseed_isa_pkg::xword_t   r [0:31];
        rvseed_isa_pkg::pc_t      pc;
        rvseed_isa_pkg::pc_t      npc;
        rvseed_isa_pkg::inst_t    w;
        rvseed_isa_pkg::xword_t   a;
        rvseed_isa_pkg::xword_t   b;
        rvseed_isa_pkg::xword_t   res;
        rvseed_isa_pkg::xword_t   immi;
        rvseed_isa_pkg::xword_t   immu;
        rvseed_isa_pkg::xword_t   immb;
        rvseed_isa_pkg::xword_t   immj;
        logic [2:0]               f3;
        logic [6:0]               f7;
        logic                     wen;
        logic                     bad;
        rvseed_ctrl_pkg::retire_t ev;
        int                       i;
        int                       steps;
        for (i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        exp_ret.delete();
        exp_ill.delete();
        pc = '0;
        steps = 0;
        while (steps < 200) begin
            w = prog[pc[7:2]];
            if (w == rvseed_isa_pkg::inst_ebreak) begin
                break;
            end
            f3   = w[14:12];
            f7   = w[31:25];
            a    = r[w[19:15]];
            b    = r[w[24:20]];
            immi = {{52{w[31]}}, w[31:20]};
            immu = {{32{w[31]}}, w[31:12], 12'b0};
            immb = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            immj = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            wen  = 1'b1;
            bad  = 1'b0;
            res  = '0;
            npc  = pc + 64'd4;
            case (w[6:0])
                rvseed_isa_pkg::op_reg: begin
                    if (f3 == 3'b000 && f7 == 7'h00) res = a + b;
                    else if (f3 == 3'b000 && f7 == 7'h20) res = a - b;
                    else bad = 1'b1;
                end
                rvseed_isa_pkg::op_reg_w: begin
                    res = a + b;
                    res = {{32{res[31]}}, res[31:0]};
                    bad = !(f3 == 3'b000 && f7 == 7'h00);
                end
                rvseed_isa_pkg::op_imm: begin
                    if (f3 == 3'b000) res = a + immi;
                    else if (f3 == 3'b011) res = {63'b0, a < immi};
                    else bad = 1'b1;
                end
                rvseed_isa_pkg::op_imm_w: begin
                    res = a + immi;
                    res = {{32{res[31]}}, res[31:0]};
                    bad = (f3 != 3'b000);
                end
                rvseed_isa_pkg::op_lui:   res = immu;
                rvseed_isa_pkg::op_auipc: res = pc + immu;
                rvseed_isa_pkg::op_jal: begin
                    res = pc + 64'd4;
                    npc = pc + immj;
                end
                rvseed_isa_pkg::op_jalr: begin
                    res = pc + 64'd4;
                    npc = (a + immi) & ~64'd1;
                    bad = (f3 != 3'b000);
                end
                rvseed_isa_pkg::op_branch: begin
                    wen = 1'b0;
                    if (f3 == 3'b000 && a == b) npc = pc + immb;
                    else if (f3 == 3'b001 && a != b) npc = pc + immb;
                    else if (f3 != 3'b000 && f3 != 3'b001) bad = 1'b1;
                end
                default: bad = 1'b1;
            endcase
            if (bad) begin
                exp_ill.push_back(w);
                npc = pc + 64'd4;
            end else begin
                ev.pc      = pc;
                ev.reg_wen = wen;
                ev.rd      = wen ? w[11:7] : 5'd0;
                ev.wdata   = wen ? res : '0;
                exp_ret.push_back(ev);
                if (wen && w[11:7] != 5'd0) r[w[11:7]] = res;
            end
            pc = npc;
            steps++;
        end
    endtask

    task automatic execute_program(input string name);
        int  i;
        int  cycles;
        int  extra;
        logic done;
        test_errors = 0;
        act_ret.delete();
        act_ill.delete();
        run_model();
        @(negedge clk);
        run = 1'b0;
        for (i = 0; i < prog_len; i++) begin
            imem_we    = 1'b1;
            imem_addr  = rvseed_isa_pkg::imem_addr_t'(i);
            imem_wdata = prog[i];
            @(negedge clk);
        end
        imem_we = 1'b0;
        arst_n = 1'b0;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        run = 1'b1;
        done = 1'b0;
        cycles = 0;
        while (!done && cycles < 500) begin
            @(negedge clk);
            cycles++;
            if (retire_valid) act_ret.push_back(retire);
            if (illegal_valid) act_ill.push_back(illegal_inst);
            if (halted) done = 1'b1;
        end
        if (!done) begin
            $display("test %s: core did not halt within 500 cycles", name);
            test_errors++;
        end else begin
            extra = 0;
            cycles = 0;
            while (cycles < 20) begin   // quiet period after halt
                @(negedge clk);
                cycles++;
                if (retire_valid || illegal_valid) extra++;
            end
            if (extra != 0) begin
                $display("test %s: core kept retiring after ebreak", name);
                test_errors++;
            end
        end
        if (act_ret.size() != exp_ret.size()) begin
            $display("ERR %s: retire count expected %0d, actual %0d", name, exp_ret.size(),
                     act_ret.size());
            test_errors++;
        end
        for (i = 0; i < act_ret.size() && i < exp_ret.size(); i++) begin
            check_retire(name, exp_ret[i], act_ret[i]);
        end
        if (act_ill.size() != exp_ill.size()) begin
            $display("ERR %s: illegal count expected %0d, actual %0d", name, exp_ill.size(),
                     act_ill.size());
            test_errors++;
        end
        for (i = 0; i < act_ill.size() && i < exp_ill.size(); i++) begin
            check_illegal(name, exp_ill[i], act_ill[i]);
        end
        run = 1'b0;
        if (test_errors == 0) begin
            $display("test %s: passed", name);
            pass_count++;
        end else begin
            $display("test %s: failed with %0d errors", name, test_errors);
            fail_count++;
        end
    endtask

    task automatic test_arith();
        prog_len = 0;
        emit(enc_addi(5'd1, 5'd0, 12'd100));
        emit(enc_addi(5'd2, 5'd0, 12'hff9));   // -7
        emit(enc_r(7'h00, 5'd2, 5'd1, 5'd3, rvseed_isa_pkg::op_reg));
        emit(enc_r(7'h20, 5'd1, 5'd2, 5'd4, rvseed_isa_pkg::op_reg));
        emit(enc_i(12'd5, 5'd2, 3'b011, 5'd5, rvseed_isa_pkg::op_imm));
        emit(enc_i(12'd200, 5'd1, 3'b011, 5'd6, rvseed_isa_pkg::op_imm));
        emit({20'h12345, 5'd7, rvseed_isa_pkg::op_lui});
        emit({20'h80000, 5'd8, rvseed_isa_pkg::op_lui});
        emit({20'h00010, 5'd9, rvseed_isa_pkg::op_auipc});
        emit(rvseed_isa_pkg::inst_ebreak);
        execute_program("arith");
    endtask

    task automatic test_word_ops();
        prog_len = 0;
        emit({20'h7ffff, 5'd1, rvseed_isa_pkg::op_lui});
        emit(enc_addi(5'd1, 5'd1, 12'h7ff));
        emit(enc_addi(5'd1, 5'd1, 12'h7ff));
        emit(enc_addi(5'd1, 5'd1, 12'h001));   // x1 = 0x7fffffff
        emit(enc_i(12'h001, 5'd1, 3'b000, 5'd2, rvseed_isa_pkg::op_imm_w));
        emit(enc_r(7'h00, 5'd1, 5'd1, 5'd3, rvseed_isa_pkg::op_reg_w));
        emit(enc_i(12'hfff, 5'd0, 3'b000, 5'd4, rvseed_isa_pkg::op_imm_w));
        emit({20'h80000, 5'd5, rvseed_isa_pkg::op_lui});
        emit(enc_r(7'h00, 5'd5, 5'd5, 5'd6, rvseed_isa_pkg::op_reg_w));
        emit(rvseed_isa_pkg::inst_ebreak);
        execute_program("word_ops");
    endtask

    task automatic test_control_flow();
        prog_len = 0;
        emit(enc_addi(5'd1, 5'd0, 12'd5));            // 0
        emit(enc_addi(5'd2, 5'd0, 12'd5));            // 4
        emit(enc_b(13'd12, 5'd2, 5'd1, 3'b000));      // 8 beq taken to 20
        emit(enc_addi(5'd10, 5'd0, 12'd1));           // 12 skipped
        emit(enc_addi(5'd10, 5'd0, 12'd2));           // 16 skipped
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b001));       // 20 bne not taken
        emit(enc_b(13'd8, 5'd0, 5'd1, 3'b000));       // 24 beq not taken
        emit(enc_addi(5'd3, 5'd0, 12'd3));            // 28
        emit(enc_b(13'd8, 5'd0, 5'd1, 3'b001));       // 32 bne taken to 40
        emit(enc_addi(5'd11, 5'd0, 12'd1));           // 36 skipped
        emit(enc_j(21'd12, 5'd5));                    // 40 jal to 52
        emit(enc_addi(5'd12, 5'd0, 12'd1));           // 44 skipped
        emit(enc_j(21'd12, 5'd0));                    // 48 jal to 60
        emit(enc_addi(5'd6, 5'd0, 12'd48));           // 52
        emit(enc_i(12'd0, 5'd6, 3'b000, 5'd7, rvseed_isa_pkg::op_jalr));    // 56 to 48
        emit(enc_i(12'd21, 5'd5, 3'b000, 5'd8, rvseed_isa_pkg::op_jalr));   // 60 lands on 64
        emit(enc_addi(5'd9, 5'd0, 12'd1));            // 64
        emit(rvseed_isa_pkg::inst_ebreak);            // 68
        execute_program("control_flow");
    endtask

    task automatic test_illegal();
        prog_len = 0;
        emit(enc_addi(5'd1, 5'd0, 12'd9));
        emit(enc_i(12'd8, 5'd2, 3'b011, 5'd1, 7'b0100011));   // sd
        emit(enc_i(12'd0, 5'd1, 3'b011, 5'd3, 7'b0000011));   // ld
        emit(32'h0000_007f);
        emit(enc_addi(5'd2, 5'd1, 12'd1));
        emit(rvseed_isa_pkg::inst_ebreak);
        execute_program("illegal");
    endtask

    task automatic test_halt_x0();
        prog_len = 0;
        emit(enc_addi(5'd0, 5'd0, 12'd55));
        emit(enc_r(7'h00, 5'd0, 5'd0, 5'd1, rvseed_isa_pkg::op_reg));
        emit(enc_addi(5'd2, 5'd0, 12'd3));
        emit(enc_r(7'h00, 5'd2, 5'd0, 5'd3, rvseed_isa_pkg::op_reg));
        emit(rvseed_isa_pkg::inst_ebreak);
        emit(enc_addi(5'd4, 5'd0, 12'd1));            // never executes
        execute_program("halt_x0");
    endtask

    task automatic test_random();
        logic [31:0] rnd;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          i;
        prog_len = 0;
        for (i = 1; i < 8; i++) begin
            rnd = $urandom;
            emit(enc_addi(5'(i), 5'd0, rnd[11:0]));
        end
        for (i = 0; i < 40; i++) begin
            rnd = $urandom;
            rd  = {2'b00, rnd[2:0]};
            rs1 = {2'b00, rnd[5:3]};
            rs2 = {2'b00, rnd[8:6]};
            case (rnd[10:9])
                2'd0: emit(enc_addi(rd, rs1, rnd[22:11]));
                2'd1: emit(enc_r(7'h00, rs2, rs1, rd, rvseed_isa_pkg::op_reg));
                2'd2: emit(enc_r(7'h20, rs2, rs1, rd, rvseed_isa_pkg::op_reg));
                default: emit(enc_i(rnd[22:11], rs1, 3'b011, rd, rvseed_isa_pkg::op_imm));
            endcase
        end
        emit(rvseed_isa_pkg::inst_ebreak);
        execute_program("random");
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        prog_len   = 0;
        pass_count = 0;
        fail_count = 0;
        void'($urandom(32'h83cc_7246));
        test_arith();
        test_word_ops();
        test_control_flow();
        test_illegal();
        test_halt_x0();
        test_random();
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: rvseed_core.f
src/rvseed_isa_pkg.sv
src/rvseed_ctrl_pkg.sv
src/inst_fetch.sv
src/fetch_queue.sv
src/ctrl.sv
src/exec_unit.sv
src/rvseed_core.sv
tests/tb_rvseed_core.sv

// File: Makefile
TOP := tb_rvseed_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f rvseed_core.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
